//--- Makefile
# Verilator build and run of the control unit testbench

BINARY := obj_dir/VtbControlUnit
SOURCES := $(shell cat tb.f)

.PHONY: all run clean

all: run

$(BINARY): tb.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module tbControlUnit -Mdir obj_dir -f tb.f

run: $(BINARY)
	./$(BINARY) | tee sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- dv/clkGen.sv
// Testbench clock and reset generator
`timescale 1ns/100ps

module clkGen #(
    parameter int resetCycles = 16
) (
    input  logic resetRequest,
    output logic clk,
    output logic reset
);

    localparam int halfPeriod = 50;

    int   porCount = resetCycles;
    logic porReset;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Power-on reset drops on a falling edge
    always @(negedge clk) begin
        if (porCount != 0) begin
            porCount <= porCount - 1;
        end
    end

    assign porReset = (porCount != 0);
    assign reset = porReset || resetRequest;

endmodule : clkGen

//--- dv/tbControlUnit.sv
// Control unit testbench with random instructions, cycle model, compare tasks and timeout
`timescale 1ns/100ps

module tbControlUnit;

    localparam int memWaitCycles = 3;
    localparam int instrTarget = 300;
    // Executed instructions take memWaitCycles plus six cycles
    localparam int cycleLimit = instrTarget * (memWaitCycles + 6) + 100;
    localparam int midResetCycles = 16;

    // MIPS encodings of the implemented instructions
    localparam logic [5:0] opcodeRType = 6'h00;
    localparam logic [5:0] opcodeAddi = 6'h08;
    localparam logic [5:0] functAdd = 6'h20;
    localparam logic [5:0] functSub = 6'h22;

    logic            clk;
    logic            reset;
    logic            resetRequest;
    ctrlPkg::opcodeT op;
    ctrlPkg::functT  funct;
    logic            pcWrite;
    logic            loadAB;
    logic            aluOutLoad;
    logic            memRead;
    logic            irWrite;
    logic            regWrite;
    ctrlPkg::srcSelT aluSrcA;
    ctrlPkg::srcSelT aluSrcB;
    ctrlPkg::aluOpT  aluOp;
    ctrlPkg::regDstT wrReg;
    ctrlPkg::wdSelT  wdReg;

    // Reference model
    ctrlPkg::seqStateE   modelState = ctrlPkg::ST_STACKINIT;
    int                  modelStep = 0;
    ctrlPkg::instrClassE modelClass = ctrlPkg::CLS_SKIP;
    int                  instrDone = 0;

    // Stack initialisation handovers seen at the DUT outputs
    int   stackInitSeen = 0;
    logic stackWritePrev = 1'b0;

    // Expected outputs for the current cycle
    logic            expPcWrite;
    logic            expLoadAB;
    logic            expAluOutLoad;
    logic            expMemRead;
    logic            expIrWrite;
    logic            expRegWrite;
    ctrlPkg::srcSelT expSrcA;
    ctrlPkg::srcSelT expSrcB;
    ctrlPkg::aluOpT  expAluOp;
    ctrlPkg::regDstT expWrReg;
    ctrlPkg::wdSelT  expWdReg;

    int   seed;
    int   resetCycle;
    int   cycleCount = 0;
    logic timedOut = 1'b0;
    int   bitErrors = 0;
    int   srcErrors = 0;
    int   aluOpErrors = 0;
    int   dstErrors = 0;
    int   wdErrors = 0;
    int   seqErrors = 0;
    int   timeoutErrors = 0;
    int   totalErrors;

    clkGen #(
        .resetCycles (16)
    ) clocks (
        .resetRequest (resetRequest),
        .clk          (clk),
        .reset        (reset)
    );

    controlUnit #(
        .memWaitCycles (memWaitCycles)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .op         (op),
        .funct      (funct),
        .pcWrite    (pcWrite),
        .loadAB     (loadAB),
        .aluOutLoad (aluOutLoad),
        .memRead    (memRead),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .aluOp      (aluOp),
        .wrReg      (wrReg),
        .wdReg      (wdReg)
    );

    function automatic ctrlPkg::instrClassE classify(input logic [5:0] opcode,
            input logic [5:0] fn);
        if (opcode == opcodeAddi) begin
            return ctrlPkg::CLS_ADDI;
        end
        if (opcode == opcodeRType && fn == functAdd) begin
            return ctrlPkg::CLS_ADD;
        end
        if (opcode == opcodeRType && fn == functSub) begin
            return ctrlPkg::CLS_SUB;
        end
        return ctrlPkg::CLS_SKIP;
    endfunction

    // Model state advances on the same edge as the DUT
    always @(posedge clk) begin
        if (reset) begin
            modelState <= ctrlPkg::ST_STACKINIT;
            modelStep <= 0;
        end else begin
            case (modelState)
                ctrlPkg::ST_STACKINIT: begin
                    modelState <= ctrlPkg::ST_FETCH;
                    modelStep <= 0;
                end
                ctrlPkg::ST_FETCH: begin
                    if (modelStep == memWaitCycles) begin
                        modelState <= ctrlPkg::ST_DECODE;
                        modelStep <= 0;
                    end else begin
                        modelStep <= modelStep + 1;
                    end
                end
                ctrlPkg::ST_DECODE: begin
                    if (modelStep == 1) begin
                        modelClass <= classify(op, funct);
                        if (classify(op, funct) == ctrlPkg::CLS_SKIP) begin
                            modelState <= ctrlPkg::ST_SKIP;
                        end else begin
                            modelState <= ctrlPkg::ST_EXECUTE;
                        end
                        modelStep <= 0;
                    end else begin
                        modelStep <= modelStep + 1;
                    end
                end
                ctrlPkg::ST_EXECUTE: begin
                    if (modelStep == 2) begin
                        modelState <= ctrlPkg::ST_FETCH;
                        modelStep <= 0;
                        instrDone <= instrDone + 1;
                    end else begin
                        modelStep <= modelStep + 1;
                    end
                end
                default: begin
                    modelState <= ctrlPkg::ST_FETCH;
                    modelStep <= 0;
                    instrDone <= instrDone + 1;
                end
            endcase
        end
    end

    task automatic setExpected();
        expPcWrite = 1'b0;
        expLoadAB = 1'b0;
        expAluOutLoad = 1'b0;
        expMemRead = 1'b0;
        expIrWrite = 1'b0;
        expRegWrite = 1'b0;
        expSrcA = ctrlPkg::SRCA_PC;
        expSrcB = ctrlPkg::SRCB_REGB;
        expAluOp = '0;
        expWrReg = ctrlPkg::DST_RT;
        expWdReg = ctrlPkg::WD_ALUOUT;
        case (modelState)
            ctrlPkg::ST_STACKINIT: begin
                expRegWrite = 1'b1;
                expWrReg = ctrlPkg::DST_STACK;
                expWdReg = ctrlPkg::WD_STACKINIT;
            end
            ctrlPkg::ST_FETCH: begin
                expSrcB = ctrlPkg::SRCB_FOUR;
                expAluOp = ctrlPkg::ALU_ADD;
                expMemRead = (modelStep < memWaitCycles);
                expPcWrite = (modelStep == memWaitCycles);
                expIrWrite = (modelStep == memWaitCycles);
            end
            ctrlPkg::ST_DECODE: begin
                if (modelStep == 0) begin
                    expSrcB = ctrlPkg::SRCB_OFFSET;
                    expAluOp = ctrlPkg::ALU_ADD;
                    expAluOutLoad = 1'b1;
                end else begin
                    expLoadAB = 1'b1;
                end
            end
            ctrlPkg::ST_EXECUTE: begin
                if (modelStep == 0) begin
                    expSrcA = ctrlPkg::SRCA_REGA;
                    if (modelClass == ctrlPkg::CLS_ADDI) begin
                        expSrcB = ctrlPkg::SRCB_IMM;
                    end
                    if (modelClass == ctrlPkg::CLS_SUB) begin
                        expAluOp = ctrlPkg::ALU_SUB;
                    end else begin
                        expAluOp = ctrlPkg::ALU_ADD;
                    end
                    expAluOutLoad = 1'b1;
                end else if (modelStep == 1) begin
                    expRegWrite = 1'b1;
                    if (modelClass != ctrlPkg::CLS_ADDI) begin
                        expWrReg = ctrlPkg::DST_RD;
                    end
                end
            end
            default: begin
                // Skip cycle is idle
            end
        endcase
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            bitErrors++;
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic checkSrc(input string name, input ctrlPkg::srcSelT actual,
            input ctrlPkg::srcSelT expected);
        if (actual !== expected) begin
            srcErrors++;
            $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkAluOp(input ctrlPkg::aluOpT actual, input ctrlPkg::aluOpT expected);
        if (actual !== expected) begin
            aluOpErrors++;
            $display("[FAIL] %0d ns: aluOp is %0d, expected %0d", $time, actual, expected);
        end
    endtask

    task automatic checkDst(input ctrlPkg::regDstT actual, input ctrlPkg::regDstT expected);
        if (actual !== expected) begin
            dstErrors++;
            $display("[FAIL] %0d ns: wrReg is %0d, expected %0d", $time, actual, expected);
        end
    endtask

    task automatic checkWd(input ctrlPkg::wdSelT actual, input ctrlPkg::wdSelT expected);
        if (actual !== expected) begin
            wdErrors++;
            $display("[FAIL] %0d ns: wdReg is %0d, expected %0d", $time, actual, expected);
        end
    endtask

    task automatic checkOutputs();
        setExpected();
        checkBit("pcWrite", pcWrite, expPcWrite);
        checkBit("loadAB", loadAB, expLoadAB);
        checkBit("aluOutLoad", aluOutLoad, expAluOutLoad);
        checkBit("memRead", memRead, expMemRead);
        checkBit("irWrite", irWrite, expIrWrite);
        checkBit("regWrite", regWrite, expRegWrite);
        checkSrc("aluSrcA", aluSrcA, expSrcA);
        checkSrc("aluSrcB", aluSrcB, expSrcB);
        checkAluOp(aluOp, expAluOp);
        checkDst(wrReg, expWrReg);
        checkWd(wdReg, expWdReg);
    endtask

    // Half implemented encodings, half arbitrary fields
    task automatic drawInstruction();
        int          kind;
        logic [31:0] fields;
        kind = {$random(seed)} % 6;
        fields = $random(seed);
        op = fields[5:0];
        funct = fields[13:8];
        case (kind)
            0: begin
                op = opcodeRType;
                funct = functAdd;
            end
            1: begin
                op = opcodeRType;
                funct = functSub;
            end
            2: begin
                op = opcodeAddi;
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        seed = 32'h3aa2_aa80;
        op = '0;
        funct = '0;
        resetRequest = 1'b0;
        resetCycle = 300 + ({$random(seed)} % 1500);

        while (instrDone < instrTarget && !timedOut) begin
            @(negedge clk);
            cycleCount++;
            checkOutputs();
            // Stack write handing over to a fresh fetch
            if (stackWritePrev && memRead) begin
                stackInitSeen++;
            end
            stackWritePrev = regWrite && (wrReg == ctrlPkg::DST_STACK);
            if (cycleCount == resetCycle) begin
                resetRequest = 1'b1;
            end else if (cycleCount == resetCycle + midResetCycles) begin
                resetRequest = 1'b0;
            end
            drawInstruction();
            if (cycleCount >= cycleLimit) begin
                timedOut = 1'b1;
                timeoutErrors++;
                $display("Timeout reached after %0d cycles with only %0d of %0d instructions done",
                    cycleCount, instrDone, instrTarget);
            end
        end

        // Power-on reset plus the one mid-run reset
        if (!timedOut && stackInitSeen != 2) begin
            seqErrors++;
            $display("Stack initialisation followed by fetch seen %0d times instead of 2",
                stackInitSeen);
        end

        totalErrors = bitErrors + srcErrors + aluOpErrors + dstErrors + wdErrors
            + seqErrors + timeoutErrors;
        $display("Errors: bit %0d src %0d aluOp %0d dst %0d wd %0d seq %0d timeout %0d",
            bitErrors, srcErrors, aluOpErrors, dstErrors, wdErrors, seqErrors, timeoutErrors);
        if (totalErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tbControlUnit

//--- hw/controlTable.sv
// Per-state and per-step table of datapath control levels
`timescale 1ns/100ps

module controlTable #(
    parameter int memWaitCycles = 3
) (
    input  ctrlPkg::seqStateE   state,
    input  ctrlPkg::stepT       step,
    input  ctrlPkg::instrClassE execClass,
    output logic                pcWrite,
    output logic                loadAB,
    output logic                aluOutLoad,
    output logic                memRead,
    output logic                irWrite,
    output logic                regWrite,
    output ctrlPkg::srcSelT     aluSrcA,
    output ctrlPkg::srcSelT     aluSrcB,
    output ctrlPkg::aluOpT      aluOp,
    output ctrlPkg::regDstT     wrReg,
    output ctrlPkg::wdSelT      wdReg
);

    localparam ctrlPkg::stepT memWaitSteps = ctrlPkg::stepT'(memWaitCycles);

    logic isAddi;
    logic isSub;

    assign isAddi = (execClass == ctrlPkg::CLS_ADDI);
    assign isSub = (execClass == ctrlPkg::CLS_SUB);

    always_comb begin
        pcWrite = 1'b0;
        loadAB = 1'b0;
        aluOutLoad = 1'b0;
        memRead = 1'b0;
        irWrite = 1'b0;
        regWrite = 1'b0;
        aluSrcA = '0;
        aluSrcB = '0;
        aluOp = '0;
        wrReg = '0;
        wdReg = '0;

        case (state)
            ctrlPkg::ST_STACKINIT: begin
                // Load the stack pointer register
                regWrite = 1'b1;
                wrReg = ctrlPkg::DST_STACK;
                wdReg = ctrlPkg::WD_STACKINIT;
            end
            ctrlPkg::ST_FETCH: begin
                // PC + 4 held across the whole fetch
                aluSrcA = ctrlPkg::SRCA_PC;
                aluSrcB = ctrlPkg::SRCB_FOUR;
                aluOp = ctrlPkg::ALU_ADD;
                if (step < memWaitSteps) begin
                    memRead = 1'b1;
                end else begin
                    pcWrite = 1'b1;
                    irWrite = 1'b1;
                end
            end
            ctrlPkg::ST_DECODE: begin
                if (step == '0) begin
                    // Branch target precomputed into ALUOut
                    aluSrcA = ctrlPkg::SRCA_PC;
                    aluSrcB = ctrlPkg::SRCB_OFFSET;
                    aluOp = ctrlPkg::ALU_ADD;
                    aluOutLoad = 1'b1;
                end else begin
                    loadAB = 1'b1;
                end
            end
            ctrlPkg::ST_EXECUTE: begin
                if (step == ctrlPkg::stepT'(0)) begin
                    aluSrcA = ctrlPkg::SRCA_REGA;
                    aluSrcB = isAddi ? ctrlPkg::SRCB_IMM : ctrlPkg::SRCB_REGB;
                    aluOp = isSub ? ctrlPkg::ALU_SUB : ctrlPkg::ALU_ADD;
                    aluOutLoad = 1'b1;
                end else if (step == ctrlPkg::stepT'(1)) begin
                    // ADDI writes rt, R-type writes rd
                    regWrite = 1'b1;
                    wrReg = isAddi ? ctrlPkg::DST_RT : ctrlPkg::DST_RD;
                    wdReg = ctrlPkg::WD_ALUOUT;
                end
            end
            default: begin
                // Skip state and anything unexpected stay idle
            end
        endcase

        // Memory port and register file never active together
        assert (!(memRead && regWrite))
            else $error("memRead and regWrite both high in state %s", state.name());
        // PC and IR update in the same cycle
        assert (pcWrite == irWrite)
            else $error("pcWrite and irWrite disagree in state %s", state.name());
    end

endmodule : controlTable

//--- hw/controlUnit.sv
// Multicycle control unit top level with decoder, sequencer and control table
`timescale 1ns/100ps

module controlUnit #(
    parameter int memWaitCycles = 3
) (
    input  logic            clk,
    input  logic            reset,

    // Instruction register fields
    input  ctrlPkg::opcodeT op,
    input  ctrlPkg::functT  funct,

    // Register load enables
    output logic            pcWrite,
    output logic            loadAB,
    output logic            aluOutLoad,
    output logic            memRead,
    output logic            irWrite,
    output logic            regWrite,

    // Datapath selects
    output ctrlPkg::srcSelT aluSrcA,
    output ctrlPkg::srcSelT aluSrcB,
    output ctrlPkg::aluOpT  aluOp,
    output ctrlPkg::regDstT wrReg,
    output ctrlPkg::wdSelT  wdReg
);

    ctrlPkg::instrClassE instrClass;
    ctrlPkg::instrClassE execClass;
    ctrlPkg::seqStateE   state;
    ctrlPkg::stepT       step;

    instrDecoder decoder (
        .op         (op),
        .funct      (funct),
        .instrClass (instrClass)
    );

    mainSequencer #(
        .memWaitCycles (memWaitCycles)
    ) sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .state      (state),
        .step       (step),
        .execClass  (execClass)
    );

    // Outputs are a Moore function of the sequencer
    controlTable #(
        .memWaitCycles (memWaitCycles)
    ) table0 (
        .state      (state),
        .step       (step),
        .execClass  (execClass),
        .pcWrite    (pcWrite),
        .loadAB     (loadAB),
        .aluOutLoad (aluOutLoad),
        .memRead    (memRead),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .aluOp      (aluOp),
        .wrReg      (wrReg),
        .wdReg      (wdReg)
    );

endmodule : controlUnit

//--- hw/ctrlPkg.sv
// Control unit field types, datapath select encodings, opcode and funct constants, enums
package ctrlPkg;

    // Instruction register fields
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // Datapath control fields
    typedef logic [2:0] aluOpT;
    typedef logic [1:0] srcSelT;
    typedef logic [1:0] regDstT;
    typedef logic [2:0] wdSelT;

    // Cycle index inside a sequencer state
    typedef logic [4:0] stepT;

    // ALU operation codes
    localparam aluOpT ALU_ADD = 3'd1;
    localparam aluOpT ALU_SUB = 3'd2;

    // ALU operand A
    localparam srcSelT SRCA_PC   = 2'd0;
    localparam srcSelT SRCA_REGA = 2'd2;

    // ALU operand B
    localparam srcSelT SRCB_REGB   = 2'd0;
    localparam srcSelT SRCB_FOUR   = 2'd1;
    localparam srcSelT SRCB_IMM    = 2'd2;
    localparam srcSelT SRCB_OFFSET = 2'd3;

    // Register file write address
    localparam regDstT DST_RT    = 2'd0;
    localparam regDstT DST_RD    = 2'd1;
    localparam regDstT DST_STACK = 2'd3;

    // Register file write data
    localparam wdSelT WD_ALUOUT    = 3'd0;
    localparam wdSelT WD_STACKINIT = 3'd6;

    // Implemented encodings only
    localparam opcodeT OP_RTYPE  = 6'd0;
    localparam opcodeT OP_ADDI   = 6'd8;
    localparam functT  FUNCT_ADD = 6'd32;
    localparam functT  FUNCT_SUB = 6'd34;

    typedef enum logic [1:0] {
        CLS_ADD,
        CLS_SUB,
        CLS_ADDI,
        CLS_SKIP
    } instrClassE;

    typedef enum logic [2:0] {
        ST_STACKINIT,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_SKIP
    } seqStateE;

endpackage : ctrlPkg

//--- hw/instrDecoder.sv
// Instruction decoder mapping opcode and funct to an instruction class
`timescale 1ns/100ps

module instrDecoder (
    input  ctrlPkg::opcodeT     op,
    input  ctrlPkg::functT      funct,
    output ctrlPkg::instrClassE instrClass
);

    always_comb begin
        // Anything not listed is skipped, legal or not
        instrClass = ctrlPkg::CLS_SKIP;
        case (op)
            ctrlPkg::OP_RTYPE: begin
                case (funct)
                    ctrlPkg::FUNCT_ADD: begin
                        instrClass = ctrlPkg::CLS_ADD;
                    end
                    ctrlPkg::FUNCT_SUB: begin
                        instrClass = ctrlPkg::CLS_SUB;
                    end
                    default: begin
                        instrClass = ctrlPkg::CLS_SKIP;
                    end
                endcase
            end
            ctrlPkg::OP_ADDI: begin
                instrClass = ctrlPkg::CLS_ADDI;
            end
            default: begin
                instrClass = ctrlPkg::CLS_SKIP;
            end
        endcase
    end

endmodule : instrDecoder

//--- hw/mainSequencer.sv
// Control unit sequencer with state register, step counter and class latch
`timescale 1ns/100ps

module mainSequencer #(
    parameter int memWaitCycles = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  ctrlPkg::instrClassE instrClass,
    output ctrlPkg::seqStateE   state,
    output ctrlPkg::stepT       step,
    output ctrlPkg::instrClassE execClass
);

    // Fetch ends one cycle after the memory wait
    localparam ctrlPkg::stepT fetchLastStep = ctrlPkg::stepT'(memWaitCycles);
    localparam ctrlPkg::stepT decodeLastStep = ctrlPkg::stepT'(1);
    localparam ctrlPkg::stepT executeLastStep = ctrlPkg::stepT'(2);

    logic              lastStep;
    ctrlPkg::seqStateE nextState;

    always_comb begin
        lastStep = 1'b1;
        nextState = state;
        case (state)
            ctrlPkg::ST_STACKINIT: begin
                nextState = ctrlPkg::ST_FETCH;
            end
            ctrlPkg::ST_FETCH: begin
                lastStep = (step == fetchLastStep);
                nextState = ctrlPkg::ST_DECODE;
            end
            ctrlPkg::ST_DECODE: begin
                lastStep = (step == decodeLastStep);
                // Dispatch on the class seen in the last decode cycle
                if (instrClass == ctrlPkg::CLS_SKIP) begin
                    nextState = ctrlPkg::ST_SKIP;
                end else begin
                    nextState = ctrlPkg::ST_EXECUTE;
                end
            end
            ctrlPkg::ST_EXECUTE: begin
                lastStep = (step == executeLastStep);
                nextState = ctrlPkg::ST_FETCH;
            end
            ctrlPkg::ST_SKIP: begin
                nextState = ctrlPkg::ST_FETCH;
            end
            default: begin
                nextState = ctrlPkg::ST_STACKINIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrlPkg::ST_STACKINIT;
            step <= '0;
            execClass <= ctrlPkg::CLS_SKIP;
        end else if (lastStep) begin
            state <= nextState;
            step <= '0;
            if (state == ctrlPkg::ST_DECODE) begin
                execClass <= instrClass;
            end
        end else begin
            step <= step + ctrlPkg::stepT'(1);
        end
    end

    // Step bounds per state
    fetchStepBound: assert property (
        @(posedge clk) disable iff (reset)
        state == ctrlPkg::ST_FETCH |-> step <= fetchLastStep
    ) else $error("fetch step %0d beyond memory wait", step);

    decodeStepBound: assert property (
        @(posedge clk) disable iff (reset)
        state == ctrlPkg::ST_DECODE |-> step <= decodeLastStep
    ) else $error("decode step %0d out of range", step);

    executeStepBound: assert property (
        @(posedge clk) disable iff (reset)
        state == ctrlPkg::ST_EXECUTE |-> step <= executeLastStep
    ) else $error("execute step %0d out of range", step);

    // Decode hands over only to execute or skip
    decodeExit: assert property (
        @(posedge clk) disable iff (reset)
        (state == ctrlPkg::ST_DECODE && step == decodeLastStep)
            |=> (state == ctrlPkg::ST_EXECUTE || state == ctrlPkg::ST_SKIP)
    ) else $error("decode left to state %s", state.name());

endmodule : mainSequencer

//--- tb.f
hw/ctrlPkg.sv
hw/instrDecoder.sv
hw/mainSequencer.sv
hw/controlTable.sv
hw/controlUnit.sv
dv/clkGen.sv
dv/tbControlUnit.sv
